/* design/eth_mac_stat_quad.sv */
// Quad MAC statistics path
`timescale 1ns/1ps
`default_nettype none

module eth_mac_stat_quad (
    input  wire logic                                                 stat_clk,
    input  wire logic                                                 rst_n,

    // Transmit events
    input  wire eth_stat_pkg::stat_byte_t [eth_stat_pkg::CH_CNT-1:0] tx_stat_byte,
    input  wire logic [eth_stat_pkg::CH_CNT-1:0]                      tx_pkt_good,
    input  wire logic [eth_stat_pkg::CH_CNT-1:0]                      tx_pkt_bad,

    // Receive events
    input  wire eth_stat_pkg::stat_byte_t [eth_stat_pkg::CH_CNT-1:0] rx_stat_byte,
    input  wire logic [eth_stat_pkg::CH_CNT-1:0]                      rx_pkt_good,
    input  wire logic [eth_stat_pkg::CH_CNT-1:0]                      rx_pkt_bad,

    // Statistics stream
    output wire logic                                                 m_axis_stat_tvalid,
    input  wire logic                                                 m_axis_stat_tready,
    output wire eth_stat_pkg::stat_id_t                               m_axis_stat_tid,
    output wire eth_stat_pkg::stat_val_t                              m_axis_stat_tdata
);
    import eth_stat_pkg::*;

    stat_msg_if tx_msg ();
    stat_msg_if rx_msg ();

    stat_counter_bank #(
        .ID_BASE(0)
    ) tx_bank (
        .stat_clk(stat_clk),
        .rst_n(rst_n),
        .byte_cnt(tx_stat_byte),
        .pkt_good(tx_pkt_good),
        .pkt_bad(tx_pkt_bad),
        .msg(tx_msg)
    );

    stat_counter_bank #(
        .ID_BASE(STAT_RX_ID_BASE)
    ) rx_bank (
        .stat_clk(stat_clk),
        .rst_n(rst_n),
        .byte_cnt(rx_stat_byte),
        .pkt_good(rx_pkt_good),
        .pkt_bad(rx_pkt_bad),
        .msg(rx_msg)
    );

    stat_arb_mux stat_mux (
        .stat_clk(stat_clk),
        .rst_n(rst_n),
        .s_tx(tx_msg),
        .s_rx(rx_msg),
        .m_valid(m_axis_stat_tvalid),
        .m_ready(m_axis_stat_tready),
        .m_id(m_axis_stat_tid),
        .m_value(m_axis_stat_tdata)
    );

endmodule

`default_nettype wire

/* design/eth_stat_pkg.sv */
// Ethernet statistics definitions
`default_nettype none

package eth_stat_pkg;

    localparam int CH_CNT = 4;
    localparam int STAT_PER_CH = 3;
    localparam int STAT_BANK_CNT = CH_CNT * STAT_PER_CH;
    localparam int STAT_UPDATE_PERIOD = 64;

    // Receive ids follow the transmit ids
    localparam int STAT_RX_ID_BASE = 12;

    localparam int STAT_IDX_W = $clog2(STAT_BANK_CNT);
    localparam int STAT_TIMER_W = $clog2(STAT_UPDATE_PERIOD);

    typedef logic [3:0] stat_byte_t;
    typedef logic [15:0] stat_val_t;
    typedef logic [7:0] stat_id_t;

    // Counter kind within a channel
    typedef enum logic [1:0] {
        BYTES = 2'd0,
        GOOD  = 2'd1,
        BAD   = 2'd2
    } stat_kind_e;

    typedef enum logic {
        SCAN_IDLE,
        SCAN_RUN
    } scan_state_e;

endpackage

`default_nettype wire

/* design/stat_arb_mux.sv */
// Round-robin statistics multiplexer
`timescale 1ns/1ps
`default_nettype none

module stat_arb_mux (
    input  wire logic                    stat_clk,
    input  wire logic                    rst_n,
    stat_msg_if.snk                      s_tx,
    stat_msg_if.snk                      s_rx,
    output logic                         m_valid,
    input  wire logic                    m_ready,
    output eth_stat_pkg::stat_id_t       m_id,
    output eth_stat_pkg::stat_val_t      m_value
);

    logic out_free;
    logic grant_rx;
    logic last_rx;
    logic take;

    // Output register empty or emptying on this edge
    assign out_free = !m_valid || m_ready;

    always_comb begin
        if (s_tx.valid && s_rx.valid) begin
            // Both request so alternate
            grant_rx = !last_rx;
        end else begin
            grant_rx = s_rx.valid;
        end
    end

    assign s_tx.ready = out_free && !grant_rx;
    assign s_rx.ready = out_free && grant_rx;

    assign take = out_free && (s_tx.valid || s_rx.valid);

    always_ff @(posedge stat_clk) begin
        if (!rst_n) begin
            m_valid <= 1'b0;
            last_rx <= 1'b0;
        end else begin
            if (take) begin
                m_valid <= 1'b1;
                last_rx <= grant_rx;
            end else if (m_ready) begin
                m_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge stat_clk) begin
        if (take) begin
            m_id <= grant_rx ? s_rx.id : s_tx.id;
            m_value <= grant_rx ? s_rx.value : s_tx.value;
        end
    end

endmodule

`default_nettype wire

/* design/stat_counter_bank.sv */
// Statistics counter bank
`timescale 1ns/1ps
`default_nettype none

module stat_counter_bank #(
    parameter int ID_BASE = 0
) (
    input  wire logic                                                 stat_clk,
    input  wire logic                                                 rst_n,
    input  wire eth_stat_pkg::stat_byte_t [eth_stat_pkg::CH_CNT-1:0] byte_cnt,
    input  wire logic [eth_stat_pkg::CH_CNT-1:0]                      pkt_good,
    input  wire logic [eth_stat_pkg::CH_CNT-1:0]                      pkt_bad,
    stat_msg_if.src                                                   msg
);
    import eth_stat_pkg::*;

    stat_val_t             cnt [STAT_BANK_CNT];
    stat_val_t             inc [STAT_BANK_CNT];
    scan_state_e           state;
    logic [STAT_IDX_W-1:0] idx;
    logic [STAT_TIMER_W-1:0] timer;
    logic                  timer_hit;
    logic                  capture;
    logic                  advance;

    function automatic stat_val_t sat_add(stat_val_t a, stat_val_t b);
        logic [$bits(stat_val_t):0] sum;
        sum = {1'b0, a} + {1'b0, b};
        return sum[$bits(stat_val_t)] ? '1 : sum[$bits(stat_val_t)-1:0];
    endfunction

    // Event inputs laid out by the id rule
    always_comb begin
        for (int ch = 0; ch < CH_CNT; ch++) begin
            inc[ch*STAT_PER_CH + int'(BYTES)] = stat_val_t'(byte_cnt[ch]);
            inc[ch*STAT_PER_CH + int'(GOOD)] = stat_val_t'(pkt_good[ch]);
            inc[ch*STAT_PER_CH + int'(BAD)] = stat_val_t'(pkt_bad[ch]);
        end
    end

    assign timer_hit = (timer == STAT_TIMER_W'(STAT_UPDATE_PERIOD - 1));

    // Nonzero counter at the scan index moves into the message
    assign capture = (state == SCAN_RUN) && !msg.valid && (cnt[idx] != '0);

    // Zero counters pass in one cycle, others on the handshake
    assign advance = (state == SCAN_RUN) &&
                     (msg.valid ? msg.ready : (cnt[idx] == '0));

    always_ff @(posedge stat_clk) begin
        if (!rst_n) begin
            for (int i = 0; i < STAT_BANK_CNT; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < STAT_BANK_CNT; i++) begin
                if (capture && idx == STAT_IDX_W'(i)) begin
                    // Restart from this cycle's event
                    cnt[i] <= inc[i];
                end else begin
                    cnt[i] <= sat_add(cnt[i], inc[i]);
                end
            end
        end
    end

    // Flush timer and scan FSM
    always_ff @(posedge stat_clk) begin
        if (!rst_n) begin
            state <= SCAN_IDLE;
            idx <= '0;
            timer <= '0;
            msg.valid <= 1'b0;
        end else begin
            timer <= timer_hit ? '0 : timer + 1'b1;

            if (capture) begin
                msg.valid <= 1'b1;
            end else if (msg.valid && msg.ready) begin
                msg.valid <= 1'b0;
            end

            case (state)
                SCAN_IDLE: begin
                    if (timer_hit) begin
                        state <= SCAN_RUN;
                        idx <= '0;
                    end
                end
                SCAN_RUN: begin
                    if (advance) begin
                        if (idx == STAT_IDX_W'(STAT_BANK_CNT - 1)) begin
                            state <= SCAN_IDLE;
                            idx <= '0;
                        end else begin
                            idx <= idx + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= SCAN_IDLE;
                end
            endcase
        end
    end

    // Message fields held until the handshake
    always_ff @(posedge stat_clk) begin
        if (capture) begin
            msg.id <= stat_id_t'(ID_BASE) + stat_id_t'(idx);
            msg.value <= cnt[idx];
        end
    end

endmodule

`default_nettype wire

/* design/stat_msg_if.sv */
// Statistic message channel
`timescale 1ns/1ps
`default_nettype none

interface stat_msg_if;
    import eth_stat_pkg::*;

    logic      valid;
    logic      ready;
    stat_id_t  id;
    stat_val_t value;

    modport src (
        output valid,
        output id,
        output value,
        input  ready
    );

    modport snk (
        input  valid,
        input  id,
        input  value,
        output ready
    );

endinterface

`default_nettype wire

/* dv/eth_mac_stat_quad_assert.sv */
// Statistics stream checks
`timescale 1ns/1ps
`default_nettype none

module eth_mac_stat_quad_assert (
    input wire logic                    stat_clk,
    input wire logic                    rst_n,
    input wire logic                    m_axis_stat_tvalid,
    input wire logic                    m_axis_stat_tready,
    input wire eth_stat_pkg::stat_id_t  m_axis_stat_tid,
    input wire eth_stat_pkg::stat_val_t m_axis_stat_tdata
);

    // Output idle coming out of reset
    reset_quiet: assert property (@(posedge stat_clk) !rst_n |=> !m_axis_stat_tvalid)
        else $error("tvalid high right after a reset cycle");

    // Stalled message keeps its fields
    hold_stalled: assert property (@(posedge stat_clk) disable iff (!rst_n)
        m_axis_stat_tvalid && !m_axis_stat_tready |=>
            m_axis_stat_tvalid && $stable(m_axis_stat_tid) && $stable(m_axis_stat_tdata))
        else $error("Stalled message changed or dropped tvalid");

    known_fields: assert property (@(posedge stat_clk) disable iff (!rst_n)
        m_axis_stat_tvalid |-> !$isunknown({m_axis_stat_tid, m_axis_stat_tdata}))
        else $error("Unknown tid or tdata while tvalid is high");

endmodule

`default_nettype wire

/* dv/eth_stat_stimulus.txt */
// Columns: dir(0 tx, 1 rx, 2 both) _ channel _ bytes _ good _ bad _ idle cycles (hex)
// One event per line, driven for one cycle
0_0_8_1_0_02
1_0_C_1_0_01
0_1_F_1_0_00
1_2_3_0_1_03
0_3_6_1_0_00
1_3_9_1_0_05
0_2_0_1_0_01
1_1_4_0_1_00
0_0_A_1_0_50
1_0_7_1_0_02
0_1_2_0_1_00
1_1_E_1_0_04
2_2_B_1_0_03
0_3_5_0_1_00
1_2_F_1_0_00
0_2_1_1_1_06
1_3_0_0_1_02
0_0_D_1_0_40
1_0_8_1_0_00
0_1_6_1_0_01
2_3_7_1_0_00
1_1_2_0_1_03
0_2_9_1_0_00
1_2_A_1_0_30
0_3_E_1_0_00
1_3_3_1_0_02
0_0_4_0_1_01
1_0_F_1_1_00
0_1_B_1_0_05
1_1_6_1_0_00
2_0_5_1_0_60
0_2_C_1_0_02
1_3_1_1_0_00

/* dv/tb_eth_mac_stat_quad.sv */
// Quad MAC statistics testbench
`timescale 1ns/1ps
`default_nettype none

module tb_eth_mac_stat_quad;
    import eth_stat_pkg::*;

    localparam int ID_CNT = 2 * STAT_BANK_CNT;
    localparam int STIM_DEPTH = 64;
    localparam int DRAIN_LIMIT = 8 * STAT_UPDATE_PERIOD;
    localparam int VAL_MAX = (1 << $bits(stat_val_t)) - 1;

    logic                    stat_clk;
    logic                    rst_n;
    stat_byte_t [CH_CNT-1:0] tx_stat_byte;
    logic [CH_CNT-1:0]       tx_pkt_good;
    logic [CH_CNT-1:0]       tx_pkt_bad;
    stat_byte_t [CH_CNT-1:0] rx_stat_byte;
    logic [CH_CNT-1:0]       rx_pkt_good;
    logic [CH_CNT-1:0]       rx_pkt_bad;
    logic                    m_axis_stat_tvalid;
    logic                    m_axis_stat_tready;
    stat_id_t                m_axis_stat_tid;
    stat_val_t               m_axis_stat_tdata;

    // Stimulus word: dir, channel, bytes, good, bad, idle cycles
    logic [27:0]       stim_mem [STIM_DEPTH];
    logic [31:0]       rng_state = 32'd60;
    int                remaining [ID_CNT];
    int                hs_count;
    int                run_cycles;

    eth_mac_stat_quad i_eth_mac_stat_quad (.*);

    bind eth_mac_stat_quad eth_mac_stat_quad_assert i_stat_assert (
        .stat_clk(stat_clk),
        .rst_n(rst_n),
        .m_axis_stat_tvalid(m_axis_stat_tvalid),
        .m_axis_stat_tready(m_axis_stat_tready),
        .m_axis_stat_tid(m_axis_stat_tid),
        .m_axis_stat_tdata(m_axis_stat_tdata)
    );

    function automatic logic [31:0] lcg_next(logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int add_sat(int total, int amount);
        return (total + amount > VAL_MAX) ? VAL_MAX : total + amount;
    endfunction

    function automatic int stat_id_of(int dir, int ch, stat_kind_e kind);
        return ((dir != 0) ? STAT_RX_ID_BASE : 0) + ch * STAT_PER_CH + int'(kind);
    endfunction

    function automatic logic drained();
        logic done;
        done = 1'b1;
        for (int i = 0; i < ID_CNT; i++) begin
            if (remaining[i] != 0) begin
                done = 1'b0;
            end
        end
        return done;
    endfunction

    task automatic stop_on_error();
        $display("Simulation failed");
        $fatal(1, "Stopped at the first error");
    endtask

    // Expected totals grow before the event is driven
    task automatic book_event(int dir, int ch, stat_byte_t nbytes, logic good, logic bad);
        remaining[stat_id_of(dir, ch, BYTES)] =
            add_sat(remaining[stat_id_of(dir, ch, BYTES)], int'(nbytes));
        remaining[stat_id_of(dir, ch, GOOD)] =
            add_sat(remaining[stat_id_of(dir, ch, GOOD)], int'(good));
        remaining[stat_id_of(dir, ch, BAD)] =
            add_sat(remaining[stat_id_of(dir, ch, BAD)], int'(bad));
    endtask

    task automatic drive_event(int dir, int ch, stat_byte_t nbytes, logic good, logic bad);
        if (dir == 0) begin
            tx_stat_byte[ch] <= nbytes;
            tx_pkt_good[ch] <= good;
            tx_pkt_bad[ch] <= bad;
        end else begin
            rx_stat_byte[ch] <= nbytes;
            rx_pkt_good[ch] <= good;
            rx_pkt_bad[ch] <= bad;
        end
    endtask

    initial stat_clk = 1'b0;
    always #4 stat_clk = ~stat_clk;

    // Random back-pressure, ready about three cycles in four
    always @(posedge stat_clk) begin
        rng_state = lcg_next(rng_state);
        m_axis_stat_tready <= (rng_state[17:16] != 2'b00);
    end

    // Output monitor
    always @(posedge stat_clk) begin
        if (rst_n) begin
            run_cycles++;
            if (run_cycles <= STAT_UPDATE_PERIOD) begin
                assert (!m_axis_stat_tvalid) else begin
                    $display("Fail at %0t ns: tvalid high before the first scan", $time);
                    stop_on_error();
                end
            end
            if (m_axis_stat_tvalid && m_axis_stat_tready) begin
                hs_count++;
                assert (m_axis_stat_tdata != '0 && int'(m_axis_stat_tid) < ID_CNT) else begin
                    $display("Fail at %0t ns: bad message id %0d value %0d", $time,
                             m_axis_stat_tid, m_axis_stat_tdata);
                    stop_on_error();
                end
                assert (int'(m_axis_stat_tdata) <= remaining[m_axis_stat_tid]) else begin
                    $display("Fail at %0t ns: id %0d value %0d exceeds remaining %0d", $time,
                             m_axis_stat_tid, m_axis_stat_tdata,
                             remaining[m_axis_stat_tid]);
                    stop_on_error();
                end
                remaining[m_axis_stat_tid] -= int'(m_axis_stat_tdata);
            end
        end
    end

    initial begin
        int line_cnt;
        int dir;
        int ch;
        int idle;
        int last_hs;
        int quiet;
        stat_byte_t nbytes;

        rst_n = 1'b0;
        tx_stat_byte = '0;
        tx_pkt_good = '0;
        tx_pkt_bad = '0;
        rx_stat_byte = '0;
        rx_pkt_good = '0;
        rx_pkt_bad = '0;
        m_axis_stat_tready = 1'b0;
        for (int i = 0; i < ID_CNT; i++) begin
            remaining[i] = 0;
        end
        for (int i = 0; i < STIM_DEPTH; i++) begin
            stim_mem[i] = '1;
        end
        $readmemh("dv/eth_stat_stimulus.txt", stim_mem);
        line_cnt = 0;
        while (line_cnt < STIM_DEPTH && stim_mem[line_cnt] != '1) begin
            line_cnt++;
        end
        assert (line_cnt > 0) else begin
            $display("The stimulus file is missing or holds no events");
            stop_on_error();
        end

        repeat (4) @(posedge stat_clk);
        rst_n <= 1'b1;

        for (int n = 0; n < line_cnt; n++) begin
            dir = int'(stim_mem[n][27:24]);
            ch = int'(stim_mem[n][23:20]);
            nbytes = stim_mem[n][19:16];
            idle = int'(stim_mem[n][7:0]);
            assert (dir <= 2 && ch < CH_CNT && (dir != 2 || nbytes != '0)) else begin
                $display("Stimulus line %0d has an invalid direction or channel", n);
                stop_on_error();
            end
            @(negedge stat_clk);
            // Direction 2 hits both banks in the same cycle
            if (dir != 1) begin
                book_event(0, ch, nbytes, stim_mem[n][12], stim_mem[n][8]);
            end
            if (dir != 0) begin
                book_event(1, ch, nbytes, stim_mem[n][12], stim_mem[n][8]);
            end
            @(posedge stat_clk);
            if (dir != 1) begin
                drive_event(0, ch, nbytes, stim_mem[n][12], stim_mem[n][8]);
            end
            if (dir != 0) begin
                drive_event(1, ch, nbytes, stim_mem[n][12], stim_mem[n][8]);
            end
            @(posedge stat_clk);
            tx_stat_byte <= '0;
            tx_pkt_good <= '0;
            tx_pkt_bad <= '0;
            rx_stat_byte <= '0;
            rx_pkt_good <= '0;
            rx_pkt_bad <= '0;
            repeat (idle) @(posedge stat_clk);
        end

        // Drain until every total is returned
        last_hs = hs_count;
        quiet = 0;
        while (!drained()) begin
            @(negedge stat_clk);
            if (hs_count != last_hs) begin
                last_hs = hs_count;
                quiet = 0;
            end else begin
                quiet++;
            end
            assert (quiet < DRAIN_LIMIT) else begin
                $display("Drain timed out after %0d cycles without an output message",
                         DRAIN_LIMIT);
                stop_on_error();
            end
        end

        // Any late extra message trips the monitor
        repeat (2 * STAT_UPDATE_PERIOD) @(posedge stat_clk);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* eth_mac_stat_quad.f */
design/eth_stat_pkg.sv
design/stat_msg_if.sv
design/stat_counter_bank.sv
design/stat_arb_mux.sv
design/eth_mac_stat_quad.sv
dv/eth_mac_stat_quad_assert.sv
dv/tb_eth_mac_stat_quad.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f eth_mac_stat_quad.f \
    --top-module tb_eth_mac_stat_quad -o tb_sim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Simulation completed successfully" sim.log && echo "PASS" && exit 0
echo "FAIL"
exit 1
